// File: logic/gpr_cfg_pkg.sv
//------------------------------------------------
// register bank geometry: widths, slot count,
// architectural and physical register numbers,
// reset value and the word/address/slot types
//------------------------------------------------
package gpr_cfg_pkg;

   localparam int DATA_W    = 32;   // word width
   localparam int ADDR_W    = 4;    // architectural address width
   localparam int NUM_SLOTS = 16;   // physical registers
   localparam int NUM_LO    = 8;    // r0-r7 visible on lo outputs

   typedef logic [DATA_W-1:0]            data_t;
   typedef logic [ADDR_W-1:0]            addr_t;
   typedef logic [$clog2(NUM_SLOTS)-1:0] slot_t;

   // architectural addresses with special meaning
   localparam addr_t ARCH_SP  = 4'd13;   // banked, msp or psp
   localparam addr_t ARCH_LR  = 4'd14;
   localparam addr_t ARCH_AUX = 4'd15;   // reads zero, writes ignored

   // physical slots above r12
   localparam slot_t SLOT_MSP = 4'd13;
   localparam slot_t SLOT_PSP = 4'd14;
   localparam slot_t SLOT_LR  = 4'd15;

   localparam data_t RESET_VAL = '1;     // every register comes up all ones

endpackage

// File: logic/gpr_ctl_pkg.sv
//------------------------------------------------
// control encodings for the register bank:
// store size of the data phase and the
// active stack pointer selection
//------------------------------------------------
package gpr_ctl_pkg;

   //------------------------------------------------
   // store size, as seen on ls_size_i
   //------------------------------------------------
   typedef enum logic [1:0] {
      LS_BYTE = 2'd0,   // byte store, replicate b0
      LS_HALF = 2'd1,   // half-word store
      LS_WORD = 2'd2,   // full word
      LS_NONE = 2'd3    // no useful store
   } ls_size_e;

   //------------------------------------------------
   // stack pointer behind address 13
   //------------------------------------------------
   typedef enum logic {
      SP_MSP = 1'b0,    // main stack
      SP_PSP = 1'b1     // process stack, reset choice
   } sp_sel_e;

endpackage

// File: logic/gpr_if.sv
//------------------------------------------------
// gpr_slot_if: decoded write and read targets,
// broadcast from the decoder to every slot
// gpr_part_if: per-slot read contributions
//------------------------------------------------
`timescale 1ns/1ps

interface gpr_slot_if;

   gpr_cfg_pkg::slot_t wr_slot;   // physical write target
   logic               wr_go;     // qualified write strobe
   gpr_cfg_pkg::data_t wdata;     // write value
   gpr_cfg_pkg::slot_t ra_slot;   // port a target
   gpr_cfg_pkg::slot_t rb_slot;   // port b target
   logic               ra_ok;     // low for address 15
   logic               rb_ok;

   modport decode (
      output wr_slot, wr_go, wdata,
      output ra_slot, rb_slot, ra_ok, rb_ok
   );

   modport slot (
      input  wr_slot, wr_go, wdata,
      input  ra_slot, rb_slot, ra_ok, rb_ok
   );

endinterface

interface gpr_part_if;

   // element k belongs to slot k, zero unless selected
   gpr_cfg_pkg::data_t ra_part [gpr_cfg_pkg::NUM_SLOTS];
   gpr_cfg_pkg::data_t rb_part [gpr_cfg_pkg::NUM_SLOTS];

   modport slot (
      output ra_part, rb_part
   );

   modport merge (
      input  ra_part, rb_part
   );

endinterface

// File: logic/gpr_write_decode.sv
//------------------------------------------------
// stack pointer select flag, architectural to
// physical slot mapping for both read ports and
// the write port, write strobe qualification
//------------------------------------------------
`timescale 1ns/1ps

module gpr_write_decode (
   input  logic               rclk1,
   input  logic               rar_reset_n,
   input  logic               hready_i,       // core advance
   input  logic               wr_en_i,
   input  logic               sp_sel_en_i,    // update the sp flag
   input  logic               sp_sel_psp_i,   // force psp
   input  logic               sp_sel_auto_i,  // take psp from sp_auto_i
   input  logic               sp_auto_i,
   input  gpr_cfg_pkg::addr_t wr_addr_i,
   input  gpr_cfg_pkg::addr_t ra_addr_i,
   input  gpr_cfg_pkg::addr_t rb_addr_i,
   input  gpr_cfg_pkg::data_t wdata_i,
   gpr_slot_if.decode         slot_o
);

   gpr_ctl_pkg::sp_sel_e sp_sel_q;     // current stack pointer
   gpr_ctl_pkg::sp_sel_e sp_sel_nxt;
   logic                 wr_ok;        // write address not aux

   // 13 steers by flag, 14 is lr, rest map straight
   function automatic gpr_cfg_pkg::slot_t arch_to_slot(
      input gpr_cfg_pkg::addr_t   addr,
      input gpr_ctl_pkg::sp_sel_e sel);
      gpr_cfg_pkg::slot_t slot;
      case (addr)
         gpr_cfg_pkg::ARCH_SP:
            slot = (sel == gpr_ctl_pkg::SP_PSP) ? gpr_cfg_pkg::SLOT_PSP
                                                : gpr_cfg_pkg::SLOT_MSP;
         gpr_cfg_pkg::ARCH_LR: slot = gpr_cfg_pkg::SLOT_LR;
         default:              slot = gpr_cfg_pkg::slot_t'(addr);   // r0-r12, aux masked
      endcase
      return slot;
   endfunction

   //------------------------------------------------
   // stack pointer select flag
   //------------------------------------------------
   assign sp_sel_nxt = (sp_sel_psp_i | (sp_sel_auto_i & sp_auto_i)) ?
                       gpr_ctl_pkg::SP_PSP : gpr_ctl_pkg::SP_MSP;

   always_ff @(posedge rclk1 or negedge rar_reset_n) begin
      if (!rar_reset_n)
         sp_sel_q <= gpr_ctl_pkg::SP_PSP;
      else if (sp_sel_en_i && hready_i)   // held while advance is low
         sp_sel_q <= sp_sel_nxt;
   end

   //------------------------------------------------
   // slot mapping and strobes
   //------------------------------------------------
   assign wr_ok          = (wr_addr_i != gpr_cfg_pkg::ARCH_AUX);
   assign slot_o.wr_slot = arch_to_slot(wr_addr_i, sp_sel_q);
   assign slot_o.wr_go   = wr_en_i & hready_i & wr_ok;
   assign slot_o.wdata   = wdata_i;

   assign slot_o.ra_slot = arch_to_slot(ra_addr_i, sp_sel_q);
   assign slot_o.rb_slot = arch_to_slot(rb_addr_i, sp_sel_q);
   assign slot_o.ra_ok   = (ra_addr_i != gpr_cfg_pkg::ARCH_AUX);   // aux reads zero
   assign slot_o.rb_ok   = (rb_addr_i != gpr_cfg_pkg::ARCH_AUX);

endmodule

// File: logic/gpr_reg_slot.sv
//------------------------------------------------
// one physical register: write match, load,
// word alignment for the stack pointer slots,
// gated contributions to both read ports
//------------------------------------------------
`timescale 1ns/1ps

module gpr_reg_slot #(
   parameter int SLOT_IDX = 0          // physical slot number
) (
   input  logic      rclk1,
   input  logic      rar_reset_n,
   gpr_slot_if.slot  slot_i,
   gpr_part_if.slot  part_o
);

   localparam gpr_cfg_pkg::slot_t MY_SLOT = gpr_cfg_pkg::slot_t'(SLOT_IDX);

   // msp and psp keep bits [1:0] at zero
   localparam logic IS_SP = (MY_SLOT == gpr_cfg_pkg::SLOT_MSP) ||
                            (MY_SLOT == gpr_cfg_pkg::SLOT_PSP);
   localparam gpr_cfg_pkg::data_t KEEP = IS_SP ? ~gpr_cfg_pkg::data_t'(3) : '1;

   gpr_cfg_pkg::data_t q;              // register contents
   logic               wr_hit;
   logic               ra_hit;
   logic               rb_hit;

   assign wr_hit = slot_i.wr_go & (slot_i.wr_slot == MY_SLOT);

   always_ff @(posedge rclk1 or negedge rar_reset_n) begin
      if (!rar_reset_n)
         q <= gpr_cfg_pkg::RESET_VAL & KEEP;
      else if (wr_hit)
         q <= slot_i.wdata & KEEP;     // align sp on the way in
   end

   //------------------------------------------------
   // read contributions, zero when not selected
   //------------------------------------------------
   assign ra_hit = slot_i.ra_ok & (slot_i.ra_slot == MY_SLOT);
   assign rb_hit = slot_i.rb_ok & (slot_i.rb_slot == MY_SLOT);

   assign part_o.ra_part[SLOT_IDX] = ra_hit ? q : '0;
   assign part_o.rb_part[SLOT_IDX] = rb_hit ? q : '0;

endmodule

// File: logic/gpr_read_merge.sv
//------------------------------------------------
// or-merge of the slot contributions into
// lo (r0-r7 only) and hi (any register) read
// data for both ports
//------------------------------------------------
`timescale 1ns/1ps

module gpr_read_merge (
   gpr_part_if.merge                part_i,
   output gpr_cfg_pkg::data_t       ra_lo_o,   // valid for r0-r7, else zero
   output gpr_cfg_pkg::data_t       ra_hi_o,   // valid for any register
   output gpr_cfg_pkg::data_t       rb_lo_o,
   output gpr_cfg_pkg::data_t       rb_hi_o
);

   // at most one slot per port is non-zero, so or is a mux
   always_comb begin
      gpr_cfg_pkg::data_t ra_lo;
      gpr_cfg_pkg::data_t ra_hi;
      gpr_cfg_pkg::data_t rb_lo;
      gpr_cfg_pkg::data_t rb_hi;

      ra_lo = '0;
      rb_lo = '0;
      for (int k = 0; k < gpr_cfg_pkg::NUM_LO; k++) begin
         ra_lo |= part_i.ra_part[k];
         rb_lo |= part_i.rb_part[k];
      end

      // hi picks up the lo result plus the upper slots
      ra_hi = ra_lo;
      rb_hi = rb_lo;
      for (int k = gpr_cfg_pkg::NUM_LO; k < gpr_cfg_pkg::NUM_SLOTS; k++) begin
         ra_hi |= part_i.ra_part[k];
         rb_hi |= part_i.rb_part[k];
      end

      ra_lo_o = ra_lo;
      ra_hi_o = ra_hi;
      rb_lo_o = rb_lo;
      rb_hi_o = rb_hi;
   end

endmodule

// File: logic/gpr_store_lanes.sv
//------------------------------------------------
// store data byte-lane replicator, little
// endian only, built from read port b data
//------------------------------------------------
`timescale 1ns/1ps

module gpr_store_lanes (
   input  gpr_cfg_pkg::data_t    rb_data_i,     // store value
   input  gpr_ctl_pkg::ls_size_e ls_size_i,
   input  logic                  write_last_i,  // bus write data phase
   output gpr_cfg_pkg::data_t    hwdata_o
);

   logic [7:0] b0;
   logic [7:0] b1;
   logic [7:0] b2;
   logic [7:0] b3;

   assign b0 = rb_data_i[7:0];
   assign b1 = rb_data_i[15:8];
   assign b2 = rb_data_i[23:16];
   assign b3 = rb_data_i[31:24];

   //------------------------------------------------
   // lanes listed 3 down to 0
   //------------------------------------------------
   always_comb begin
      if (write_last_i) begin
         case (ls_size_i)
            gpr_ctl_pkg::LS_BYTE: hwdata_o = {b0, b0, b0, b0};   // every lane
            gpr_ctl_pkg::LS_HALF: hwdata_o = {b1, b0, b1, b0};   // both halves
            gpr_ctl_pkg::LS_WORD: hwdata_o = {b3, b2, b1, b0};
            default:              hwdata_o = {8'h00, b0, b1, b0};
         endcase
      end
      else begin
         // not in a write data phase
         hwdata_o = {8'h00, b0, b1, 8'h00};
      end
   end

endmodule

// File: logic/gpr_bank.sv
//------------------------------------------------
// register bank top: write/select decoder,
// sixteen register slots, read merger and the
// store lane replicator, plain ports only
//------------------------------------------------
`timescale 1ns/1ps

module gpr_bank (
   input  logic                             rclk1,
   input  logic                             rar_reset_n,

   // core control
   input  logic                             hready_i,       // advance, low holds all state
   input  logic                             wr_en_i,
   input  logic                             sp_sel_en_i,
   input  logic                             sp_sel_psp_i,
   input  logic                             sp_sel_auto_i,
   input  logic                             sp_auto_i,      // control bit choice of sp
   input  logic                             write_last_i,

   // addresses and data
   input  logic [gpr_cfg_pkg::ADDR_W-1:0]   wr_addr_i,
   input  logic [gpr_cfg_pkg::ADDR_W-1:0]   ra_addr_i,
   input  logic [gpr_cfg_pkg::ADDR_W-1:0]   rb_addr_i,
   input  logic [1:0]                       ls_size_i,      // store size encoding
   input  logic [gpr_cfg_pkg::DATA_W-1:0]   wdata_i,

   // read ports and bus write data
   output logic [gpr_cfg_pkg::DATA_W-1:0]   ra_data_lo_o,
   output logic [gpr_cfg_pkg::DATA_W-1:0]   ra_data_hi_o,
   output logic [gpr_cfg_pkg::DATA_W-1:0]   rb_data_lo_o,
   output logic [gpr_cfg_pkg::DATA_W-1:0]   rb_data_hi_o,
   output logic [gpr_cfg_pkg::DATA_W-1:0]   hwdata_o
);

   gpr_slot_if u_slot_if ();   // decoder to slots
   gpr_part_if u_part_if ();   // slots to merger

   //------------------------------------------------
   // write and select decode
   //------------------------------------------------
   gpr_write_decode u_decode (
      .rclk1         (rclk1),
      .rar_reset_n   (rar_reset_n),
      .hready_i      (hready_i),
      .wr_en_i       (wr_en_i),
      .sp_sel_en_i   (sp_sel_en_i),
      .sp_sel_psp_i  (sp_sel_psp_i),
      .sp_sel_auto_i (sp_sel_auto_i),
      .sp_auto_i     (sp_auto_i),
      .wr_addr_i     (wr_addr_i),
      .ra_addr_i     (ra_addr_i),
      .rb_addr_i     (rb_addr_i),
      .wdata_i       (wdata_i),
      .slot_o        (u_slot_if.decode)
   );

   //------------------------------------------------
   // physical registers, r0-r12, msp, psp, lr
   //------------------------------------------------
   for (genvar k = 0; k < gpr_cfg_pkg::NUM_SLOTS; k++) begin : g_slot
      gpr_reg_slot #(
         .SLOT_IDX (k)
      ) u_slot (
         .rclk1       (rclk1),
         .rar_reset_n (rar_reset_n),
         .slot_i      (u_slot_if.slot),
         .part_o      (u_part_if.slot)
      );
   end

   //------------------------------------------------
   // read data and store lanes
   //------------------------------------------------
   gpr_read_merge u_merge (
      .part_i  (u_part_if.merge),
      .ra_lo_o (ra_data_lo_o),
      .ra_hi_o (ra_data_hi_o),
      .rb_lo_o (rb_data_lo_o),
      .rb_hi_o (rb_data_hi_o)
   );

   // store value comes from port b hi
   gpr_store_lanes u_lanes (
      .rb_data_i    (rb_data_hi_o),
      .ls_size_i    (gpr_ctl_pkg::ls_size_e'(ls_size_i)),
      .write_last_i (write_last_i),
      .hwdata_o     (hwdata_o)
   );

endmodule

// File: tests/gpr_checker.sv
//------------------------------------------------
// register bank checker: model of r0-r12, lr,
// both stack pointers and the select flag,
// per-cycle compare and per-test counts
//------------------------------------------------
`timescale 1ns/1ps

module gpr_checker (
   input logic        rclk1,
   input logic        rar_reset_n,
   input logic        hready_i,
   input logic        wr_en_i,
   input logic        sp_sel_en_i,
   input logic        sp_sel_psp_i,
   input logic        sp_sel_auto_i,
   input logic        sp_auto_i,
   input logic        write_last_i,
   input logic [3:0]  wr_addr_i,
   input logic [3:0]  ra_addr_i,
   input logic [3:0]  rb_addr_i,
   input logic [1:0]  ls_size_i,
   input logic [31:0] wdata_i,
   input logic [31:0] ra_lo_i,      // DUT read data
   input logic [31:0] ra_hi_i,
   input logic [31:0] rb_lo_i,
   input logic [31:0] rb_hi_i,
   input logic [31:0] hwdata_i      // DUT store lanes
);

   logic [31:0] gpr_m [0:12];       // r0-r12
   logic [31:0] msp_m;
   logic [31:0] psp_m;
   logic [31:0] lr_m;
   logic        psp_sel_m;          // address 13 means psp
   string       cur_test = "";
   logic        checking = 1'b0;
   int          test_errs = 0;
   int          tests_passed = 0;
   int          tests_failed = 0;
   int          mismatch_total = 0;

   // expected hi value of an architectural address
   function automatic logic [31:0] model_read(input logic [3:0] addr);
      case (addr)
         4'd13:   return psp_sel_m ? psp_m : msp_m;
         4'd14:   return lr_m;
         4'd15:   return 32'h0;      // aux gone, reads zero
         default: return gpr_m[addr];
      endcase
   endfunction

   // bytes listed lane 3 down to lane 0
   function automatic logic [31:0] model_lanes(input logic [31:0] w, input logic [1:0] size,
                                               input logic last);
      if (!last)
         return {8'h00, w[7:0], w[15:8], 8'h00};
      case (size)
         2'd0:    return {w[7:0], w[7:0], w[7:0], w[7:0]};
         2'd1:    return {w[15:8], w[7:0], w[15:8], w[7:0]};
         2'd2:    return w;
         default: return {8'h00, w[7:0], w[15:8], w[7:0]};
      endcase
   endfunction

   //------------------------------------------------
   // model state, follows the pins at each edge
   //------------------------------------------------
   always @(posedge rclk1 or negedge rar_reset_n) begin
      if (!rar_reset_n) begin
         for (int k = 0; k < 13; k++)
            gpr_m[k] = 32'hffff_ffff;
         lr_m      = 32'hffff_ffff;
         msp_m     = 32'hffff_fffc;   // word aligned
         psp_m     = 32'hffff_fffc;
         psp_sel_m = 1'b1;
      end
      else if (hready_i) begin
         if (wr_en_i && wr_addr_i == 4'd13 && psp_sel_m)
            psp_m = {wdata_i[31:2], 2'b00};
         else if (wr_en_i && wr_addr_i == 4'd13)
            msp_m = {wdata_i[31:2], 2'b00};
         else if (wr_en_i && wr_addr_i == 4'd14)
            lr_m = wdata_i;
         else if (wr_en_i && wr_addr_i < 4'd13)
            gpr_m[wr_addr_i] = wdata_i;
         if (sp_sel_en_i)   // flag after the write, old flag steers it
            psp_sel_m = sp_sel_psp_i | (sp_sel_auto_i & sp_auto_i);
      end
   end

   task automatic compare_word(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
      if (act !== exp) begin
         $display("mismatch %s %s expected %h actual %h", cur_test, what, exp, act);
         test_errs++;
         mismatch_total++;
      end
   endtask

   //------------------------------------------------
   // compare 1 ns ahead of each rising edge
   //------------------------------------------------
   always @(negedge rclk1) begin
      #3;
      if (checking && rar_reset_n) begin
         compare_word("ra_hi", model_read(ra_addr_i), ra_hi_i);
         compare_word("rb_hi", model_read(rb_addr_i), rb_hi_i);
         compare_word("ra_lo", (ra_addr_i < 4'd8) ? model_read(ra_addr_i) : 32'h0, ra_lo_i);
         compare_word("rb_lo", (rb_addr_i < 4'd8) ? model_read(rb_addr_i) : 32'h0, rb_lo_i);
         compare_word("hwdata", model_lanes(model_read(rb_addr_i), ls_size_i, write_last_i),
                      hwdata_i);
      end
   end

   task start_test(input string name);
      cur_test  = name;
      test_errs = 0;
      checking  = 1'b1;
   endtask

   task finish_test();
      checking = 1'b0;
      if (test_errs == 0) begin
         tests_passed++;
         $display("test %s passed", cur_test);
      end
      else begin
         tests_failed++;
         $display("test %s failed with %0d mismatches", cur_test, test_errs);
      end
   endtask

endmodule

// File: tests/tb_gpr_bank.sv
//------------------------------------------------
// register bank testbench: clock, reset, lcg,
// directed and random stimulus, watchdog,
// DUT and checker instances
//------------------------------------------------
`timescale 1ns/1ps

module tb_gpr_bank;

   localparam int RESET_CYC = 10;
   localparam int N_RAND    = 40;   // write/readback pairs
   localparam int N_LANE    = 12;   // store lane rounds
   // cycles per test plus one closing cycle each
   localparam int OPS_TOTAL = RESET_CYC + 17 + (2 * N_RAND + 1) + 9 + 16 + (4 * N_LANE + 1) + 18;
   localparam int LIMIT_NS  = OPS_TOTAL * 8 * 4;

   logic        rclk1 = 1'b0;
   logic        rar_reset_n, hready_i, wr_en_i, write_last_i;
   logic        sp_sel_en_i, sp_sel_psp_i, sp_sel_auto_i, sp_auto_i;
   logic [3:0]  wr_addr_i, ra_addr_i, rb_addr_i;
   logic [1:0]  ls_size_i;
   logic [31:0] wdata_i, ra_lo, ra_hi, rb_lo, rb_hi, hwdata;
   logic [31:0] lcg_state = 32'h7f8a7d96;

   gpr_bank DUT (
      .rclk1 (rclk1), .rar_reset_n (rar_reset_n), .hready_i (hready_i),
      .wr_en_i (wr_en_i), .sp_sel_en_i (sp_sel_en_i), .sp_sel_psp_i (sp_sel_psp_i),
      .sp_sel_auto_i (sp_sel_auto_i), .sp_auto_i (sp_auto_i), .write_last_i (write_last_i),
      .wr_addr_i (wr_addr_i), .ra_addr_i (ra_addr_i), .rb_addr_i (rb_addr_i),
      .ls_size_i (ls_size_i), .wdata_i (wdata_i), .ra_data_lo_o (ra_lo),
      .ra_data_hi_o (ra_hi), .rb_data_lo_o (rb_lo), .rb_data_hi_o (rb_hi), .hwdata_o (hwdata)
   );

   gpr_checker u_checker (
      .rclk1 (rclk1), .rar_reset_n (rar_reset_n), .hready_i (hready_i),
      .wr_en_i (wr_en_i), .sp_sel_en_i (sp_sel_en_i), .sp_sel_psp_i (sp_sel_psp_i),
      .sp_sel_auto_i (sp_sel_auto_i), .sp_auto_i (sp_auto_i), .write_last_i (write_last_i),
      .wr_addr_i (wr_addr_i), .ra_addr_i (ra_addr_i), .rb_addr_i (rb_addr_i),
      .ls_size_i (ls_size_i), .wdata_i (wdata_i), .ra_lo_i (ra_lo), .ra_hi_i (ra_hi),
      .rb_lo_i (rb_lo), .rb_hi_i (rb_hi), .hwdata_i (hwdata)
   );

   always #4 rclk1 = ~rclk1;   // 8 ns period

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic logic [3:0] rand_addr();   // r0-r14 only
      logic [31:0] r;
      r = lcg_next();
      return 4'((r >> 8) % 15);
   endfunction

   //------------------------------------------------
   // each driver owns one cycle from a falling edge
   //------------------------------------------------
   task automatic set_idle();
      hready_i      = 1'b1;
      wr_en_i       = 1'b0;
      sp_sel_en_i   = 1'b0;
      sp_sel_psp_i  = 1'b0;
      sp_sel_auto_i = 1'b0;
      sp_auto_i     = 1'b0;
      write_last_i  = 1'b0;
      ls_size_i     = gpr_ctl_pkg::LS_NONE;
   endtask

   task automatic write_reg(input logic hr, input logic we, input logic [3:0] wa,
                            input logic [31:0] wd, input logic [3:0] ra, input logic [3:0] rb);
      @(negedge rclk1);
      set_idle();
      hready_i  = hr;
      wr_en_i   = we;
      wr_addr_i = wa;
      wdata_i   = wd;
      ra_addr_i = ra;
      rb_addr_i = rb;
   endtask

   task automatic read_reg(input logic [3:0] a);
      write_reg(1'b1, 1'b0, 4'd0, 32'h0, a, a);
   endtask

   task automatic select_sp(input logic hr, input logic psp, input logic auto_sel,
                            input logic auto_bit);
      @(negedge rclk1);
      set_idle();
      hready_i      = hr;
      sp_sel_en_i   = 1'b1;
      sp_sel_psp_i  = psp;
      sp_sel_auto_i = auto_sel;
      sp_auto_i     = auto_bit;
      ra_addr_i     = 4'd13;   // watch the banked sp meanwhile
      rb_addr_i     = 4'd13;
   endtask

   task automatic store_word(input logic [3:0] a, input logic [1:0] size);
      @(negedge rclk1);
      set_idle();
      ra_addr_i    = a;
      rb_addr_i    = a;
      write_last_i = 1'b1;
      ls_size_i    = size;
   endtask

   task automatic end_test();
      @(negedge rclk1);
      set_idle();
      u_checker.finish_test();
   endtask

   //------------------------------------------------
   // watchdog
   //------------------------------------------------
   initial begin
      #(LIMIT_NS);
      $display("simulation timed out after %0d ns before the tests finished", LIMIT_NS);
      $display(">>> FAIL");
      $finish;
   end

   initial begin
      logic [3:0] a;
      set_idle();
      wr_addr_i   = 4'd0;
      ra_addr_i   = 4'd0;
      rb_addr_i   = 4'd0;
      wdata_i     = 32'h0;
      rar_reset_n = 1'b0;
      repeat (RESET_CYC) @(negedge rclk1);
      rar_reset_n = 1'b1;

      u_checker.start_test("reset_values");
      for (int k = 0; k < 16; k++)
         read_reg(4'(k));
      end_test();

      u_checker.start_test("random_write");
      for (int n = 0; n < N_RAND; n++) begin
         a = rand_addr();
         write_reg(1'b1, 1'b1, a, lcg_next(), lcg_state[27:24], lcg_state[19:16]);
         read_reg(a);
      end
      end_test();

      u_checker.start_test("hold_state");
      write_reg(1'b1, 1'b1, 4'd13, 32'h2468_ace1, 4'd13, 4'd13);   // psp known
      write_reg(1'b1, 1'b1, 4'd3, 32'h1357_9bdf, 4'd3, 4'd3);
      write_reg(1'b0, 1'b1, 4'd3, 32'hdead_beef, 4'd3, 4'd3);      // advance low
      read_reg(4'd3);
      write_reg(1'b1, 1'b0, 4'd5, 32'hcafe_f00d, 4'd5, 4'd5);      // enable low
      read_reg(4'd5);
      select_sp(1'b0, 1'b0, 1'b0, 1'b0);   // would pick msp
      read_reg(4'd13);
      end_test();

      u_checker.start_test("stack_banks");
      select_sp(1'b1, 1'b0, 1'b0, 1'b0);   // msp untouched since reset
      read_reg(4'd13);
      select_sp(1'b1, 1'b1, 1'b0, 1'b0);
      write_reg(1'b1, 1'b1, 4'd13, 32'ha5a5_a5a7, 4'd13, 4'd13);
      select_sp(1'b1, 1'b0, 1'b0, 1'b0);
      write_reg(1'b1, 1'b1, 4'd13, 32'h5a5a_5a5b, 4'd13, 4'd13);
      read_reg(4'd13);
      select_sp(1'b1, 1'b1, 1'b0, 1'b0);
      read_reg(4'd13);
      select_sp(1'b1, 1'b0, 1'b1, 1'b0);   // auto with bit low
      read_reg(4'd13);
      select_sp(1'b1, 1'b0, 1'b1, 1'b1);   // auto with bit high
      read_reg(4'd13);
      select_sp(1'b1, 1'b0, 1'b0, 1'b1);   // bit without auto
      read_reg(4'd13);
      end_test();

      u_checker.start_test("store_lanes");
      for (int n = 0; n < N_LANE; n++) begin
         a = rand_addr();
         write_reg(1'b1, 1'b1, a, lcg_next(), a, a);
         store_word(a, gpr_ctl_pkg::LS_BYTE);
         store_word(a, gpr_ctl_pkg::LS_HALF);
         store_word(a, gpr_ctl_pkg::LS_WORD);
      end
      end_test();

      u_checker.start_test("aux_address");
      write_reg(1'b1, 1'b1, 4'd15, lcg_next(), 4'd15, 4'd15);
      read_reg(4'd15);
      for (int k = 0; k < 15; k++)   // nothing else moved
         read_reg(4'(k));
      end_test();

      $display("tests passed %0d, tests failed %0d",
               u_checker.tests_passed, u_checker.tests_failed);
      if (u_checker.tests_failed == 0 && u_checker.mismatch_total == 0)
         $display(">>> PASS");
      else
         $display(">>> FAIL");
      $finish;
   end

endmodule

// File: gpr_bank.f
logic/gpr_cfg_pkg.sv
logic/gpr_ctl_pkg.sv
logic/gpr_if.sv
logic/gpr_write_decode.sv
logic/gpr_reg_slot.sv
logic/gpr_read_merge.sv
logic/gpr_store_lanes.sv
logic/gpr_bank.sv
tests/gpr_checker.sv
tests/tb_gpr_bank.sv
